// File: source/ndn_pkg.sv
package ndn_pkg;

    localparam int PIT_DEPTH = 16;                     // pit and content store slots
    localparam int FIB_DEPTH = 8;                      // route entries

    typedef logic [63:0]                    name_t;     // msb-aligned name prefix
    typedef logic [5:0]                     name_len_t; // prefix length in bits
    typedef logic [7:0]                     byte_t;     // one payload byte
    typedef logic [$clog2(PIT_DEPTH)-1:0]   slot_t;     // hash slot
    typedef logic [$clog2(FIB_DEPTH)-1:0]   fib_idx_t;  // route table index

    typedef struct packed {
        name_t     name;
        name_len_t len;
    } interest_t;                                      // 70 bits

    typedef struct packed {
        name_t     name;
        name_len_t len;
        byte_t     payload;
    } data_t;                                          // 78 bits

    typedef struct packed {
        name_t     prefix;
        name_len_t len;
    } route_t;                                         // 70 bits

    typedef enum logic [2:0] {
        RESP_FWD, RESP_AGGR, RESP_CACHE, RESP_NACK_COLLIDE,
        RESP_NACK_NOROUTE, RESP_DELIVER, RESP_DROP
    } resp_kind_e;

    typedef struct packed {
        resp_kind_e kind;
        name_t      name;
        name_len_t  len;
        byte_t      payload;
        route_t     route;
    } resp_t;                                          // 151 bits

    typedef enum logic [1:0] {TBL_LOOKUP, TBL_INSERT, TBL_REMOVE} tbl_op_e;

    typedef enum logic [2:0] {
        ST_IDLE, ST_LOOKUP, ST_DECIDE, ST_ROUTE_WAIT, ST_EMIT
    } pit_state_e;

    // ones over the top len bits of a name
    function automatic name_t prefix_mask(input name_len_t len);
        name_t ones;
        ones = '1;
        return ~(ones >> len);
    endfunction

endpackage

// File: source/pit_hash_table.sv
`timescale 1ns/100ps

module pit_hash_table (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req_valid,
    input  ndn_pkg::tbl_op_e   req_op,
    input  ndn_pkg::name_t     req_name,
    input  ndn_pkg::name_len_t req_len,
    output logic               rsp_occupied,
    output ndn_pkg::name_t     rsp_name,
    output ndn_pkg::name_len_t rsp_len,
    output ndn_pkg::slot_t     rsp_slot
);
    import ndn_pkg::*;

    logic [PIT_DEPTH-1:0] slot_valid;                  // pending bit per slot
    interest_t            slot_entry [PIT_DEPTH];      // stored name and length
    interest_t            rsp_entry;                   // registered lookup result
    slot_t                req_slot;

    // xor of all nibbles after masking off bits below len
    function automatic slot_t name_hash(input name_t name, input name_len_t len);
        name_t masked;
        slot_t h;
        masked = name & prefix_mask(len);
        h = '0;
        for (int i = 0; i < $bits(name_t) / $bits(slot_t); i++) begin
            h = h ^ masked[i*$bits(slot_t) +: $bits(slot_t)];
        end
        return h;
    endfunction

    assign req_slot = name_hash(req_name, req_len); // slot of current request
    assign rsp_slot = req_slot;                      // comb, for store addressing

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot_valid   <= '0;                      // table empty
            rsp_occupied <= 1'b0;
        end else if (req_valid) begin
            case (req_op)
                TBL_LOOKUP: rsp_occupied <= slot_valid[req_slot];
                TBL_INSERT: slot_valid[req_slot] <= 1'b1;
                TBL_REMOVE: slot_valid[req_slot] <= 1'b0;
                default:    rsp_occupied <= 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_op == TBL_INSERT) begin
            slot_entry[req_slot] <= '{name: req_name & prefix_mask(req_len), len: req_len};
        end
        if (req_valid && req_op == TBL_LOOKUP) begin
            rsp_entry <= slot_entry[req_slot];       // one cycle read latency
        end
    end

    assign rsp_name = rsp_entry.name;
    assign rsp_len  = rsp_entry.len;

endmodule

// File: source/fib.sv
`timescale 1ns/100ps

module fib (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wr_valid,
    input  ndn_pkg::fib_idx_t  wr_idx,
    input  ndn_pkg::route_t    wr_route,
    input  logic               req_valid,
    input  ndn_pkg::name_t     req_name,
    input  ndn_pkg::name_len_t req_len,
    output logic               rsp_valid,
    output logic               rsp_hit,
    output ndn_pkg::route_t    rsp_route
);
    import ndn_pkg::*;

    route_t               entry [FIB_DEPTH];           // programmed routes
    logic [FIB_DEPTH-1:0] entry_valid;                 // written flags
    logic [FIB_DEPTH-1:0] entry_match;                 // per-entry prefix hit
    logic                 best_found;
    route_t               best_route;

    // all entries compared in parallel
    always_comb begin
        for (int i = 0; i < FIB_DEPTH; i++) begin
            entry_match[i] = entry_valid[i] && (entry[i].len <= req_len) &&
                (((entry[i].prefix ^ req_name) & prefix_mask(entry[i].len)) == '0);
        end
    end

    // longest wins, strict compare keeps lowest index on a tie
    always_comb begin
        best_found = 1'b0;
        best_route = '0;
        for (int i = 0; i < FIB_DEPTH; i++) begin
            if (entry_match[i] && (!best_found || entry[i].len > best_route.len)) begin
                best_found = 1'b1;
                best_route = entry[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            entry_valid <= '0;                       // no routes after reset
        end else if (wr_valid) begin
            entry_valid[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_valid) begin
            entry[wr_idx] <= wr_route;               // seen from next lookup on
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
            rsp_hit   <= 1'b0;
        end else begin
            rsp_valid <= req_valid;                  // fixed one cycle latency
            if (req_valid) begin
                rsp_hit <= best_found;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            rsp_route <= best_route;
        end
    end

endmodule

// File: source/content_store.sv
`timescale 1ns/100ps

module content_store (
    input  logic               clk,
    input  logic               rst_n,
    input  ndn_pkg::slot_t     addr,
    input  logic               we,
    input  ndn_pkg::name_t     wr_name,
    input  ndn_pkg::name_len_t wr_len,
    input  ndn_pkg::byte_t     wr_byte,
    output logic               rd_valid,
    output ndn_pkg::name_t     rd_name,
    output ndn_pkg::name_len_t rd_len,
    output ndn_pkg::byte_t     rd_byte
);
    import ndn_pkg::*;

    data_t                mem [PIT_DEPTH];             // cached name, len, byte
    logic [PIT_DEPTH-1:0] mem_valid;                   // slot holds a record
    data_t                rd_rec;

    // single port, read returns old contents on a write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= '{name: wr_name, len: wr_len, payload: wr_byte};
        end
        rd_rec <= mem[addr];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_valid <= '0;                         // store empty
            rd_valid  <= 1'b0;
        end else begin
            if (we) begin
                mem_valid[addr] <= 1'b1;             // overwrite slot on fill
            end
            rd_valid <= mem_valid[addr];
        end
    end

    assign rd_name = rd_rec.name;
    assign rd_len  = rd_rec.len;
    assign rd_byte = rd_rec.payload;

endmodule

// File: source/pit.sv
`timescale 1ns/100ps

module pit (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               interest_valid,
    output logic               interest_ready,
    input  ndn_pkg::interest_t interest,
    input  logic               data_valid,
    output logic               data_ready,
    input  ndn_pkg::data_t     data,
    output logic               tbl_req_valid,
    output ndn_pkg::tbl_op_e   tbl_req_op,
    output ndn_pkg::name_t     tbl_req_name,
    output ndn_pkg::name_len_t tbl_req_len,
    input  logic               tbl_rsp_occupied,
    input  ndn_pkg::name_t     tbl_rsp_name,
    input  ndn_pkg::name_len_t tbl_rsp_len,
    input  ndn_pkg::slot_t     tbl_rsp_slot,
    output ndn_pkg::slot_t     cs_addr,
    output logic               cs_we,
    output ndn_pkg::name_t     cs_wr_name,
    output ndn_pkg::name_len_t cs_wr_len,
    output ndn_pkg::byte_t     cs_wr_byte,
    input  logic               cs_rd_valid,
    input  ndn_pkg::name_t     cs_rd_name,
    input  ndn_pkg::name_len_t cs_rd_len,
    input  ndn_pkg::byte_t     cs_rd_byte,
    output logic               fib_req_valid,
    output ndn_pkg::name_t     fib_req_name,
    output ndn_pkg::name_len_t fib_req_len,
    input  logic               fib_rsp_valid,
    input  logic               fib_rsp_hit,
    input  ndn_pkg::route_t    fib_rsp_route,
    output logic               out_valid,
    input  logic               out_ready,
    output ndn_pkg::resp_t     resp
);
    import ndn_pkg::*;

    pit_state_e state;
    pit_state_e state_next;
    logic       pkt_is_data;                           // packet in flight is data
    name_t      pkt_name;                              // masked to pkt_len
    name_len_t  pkt_len;
    byte_t      pkt_byte;
    logic       take_data;
    logic       take_interest;
    logic       tbl_same;                              // slot pends this very name
    logic       cs_hit;                                // store holds this name
    resp_t      resp_next;
    logic       resp_load;

    assign data_ready     = (state == ST_IDLE);
    assign interest_ready = (state == ST_IDLE) && !data_valid; // data goes first
    assign take_data      = data_valid && data_ready;
    assign take_interest  = interest_valid && interest_ready;
    assign out_valid      = (state == ST_EMIT);

    // tables always see the held packet
    assign tbl_req_name = pkt_name;
    assign tbl_req_len  = pkt_len;
    assign fib_req_name = pkt_name;
    assign fib_req_len  = pkt_len;
    assign cs_addr      = tbl_rsp_slot;                // same slot for read and fill
    assign cs_wr_name   = pkt_name;
    assign cs_wr_len    = pkt_len;
    assign cs_wr_byte   = pkt_byte;

    assign tbl_same = tbl_rsp_occupied && (tbl_rsp_name == pkt_name) && (tbl_rsp_len == pkt_len);
    assign cs_hit   = cs_rd_valid && (cs_rd_name == pkt_name) && (cs_rd_len == pkt_len);

    always_comb begin
        state_next     = state;
        tbl_req_valid  = 1'b0;
        tbl_req_op     = TBL_LOOKUP;
        cs_we          = 1'b0;
        fib_req_valid  = 1'b0;
        resp_load      = 1'b0;
        resp_next      = '0;
        resp_next.kind = RESP_DROP;
        resp_next.name = pkt_name;
        resp_next.len  = pkt_len;
        unique case (state)
            ST_IDLE: begin
                if (take_data || take_interest) begin
                    state_next = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin                          // pit lookup and store read
                tbl_req_valid = 1'b1;
                state_next    = ST_DECIDE;
            end
            ST_DECIDE: begin
                resp_load  = 1'b1;
                state_next = ST_EMIT;
                if (pkt_is_data) begin
                    if (tbl_same) begin                // satisfies a pending entry
                        tbl_req_valid     = 1'b1;
                        tbl_req_op        = TBL_REMOVE;
                        cs_we             = 1'b1;      // cache the byte
                        resp_next.kind    = RESP_DELIVER;
                        resp_next.payload = pkt_byte;
                    end
                end else if (cs_hit) begin
                    resp_next.kind    = RESP_CACHE;
                    resp_next.payload = cs_rd_byte;
                end else if (tbl_same) begin
                    resp_next.kind = RESP_AGGR;
                end else if (tbl_rsp_occupied) begin
                    resp_next.kind = RESP_NACK_COLLIDE; // slot taken by another name
                end else begin
                    resp_load     = 1'b0;
                    fib_req_valid = 1'b1;             // empty slot, go route
                    state_next    = ST_ROUTE_WAIT;
                end
            end
            ST_ROUTE_WAIT: begin
                if (fib_rsp_valid) begin
                    resp_load  = 1'b1;
                    state_next = ST_EMIT;
                    if (fib_rsp_hit) begin
                        tbl_req_valid   = 1'b1;
                        tbl_req_op      = TBL_INSERT; // now pending
                        resp_next.kind  = RESP_FWD;
                        resp_next.route = fib_rsp_route;
                    end else begin
                        resp_next.kind = RESP_NACK_NOROUTE;
                    end
                end
            end
            ST_EMIT: begin
                if (out_ready) begin
                    state_next = ST_IDLE;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= ST_IDLE;
            pkt_is_data <= 1'b0;
        end else begin
            state <= state_next;
            if (take_data || take_interest) begin
                pkt_is_data <= take_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_data) begin
            pkt_name <= data.name & prefix_mask(data.len);
            pkt_len  <= data.len;
            pkt_byte <= data.payload;
        end else if (take_interest) begin
            pkt_name <= interest.name & prefix_mask(interest.len);
            pkt_len  <= interest.len;
            pkt_byte <= '0;                          // interests carry no byte
        end
        if (resp_load) begin
            resp <= resp_next;                       // held through back-pressure
        end
    end

endmodule

// File: source/ndn.sv
`timescale 1ns/100ps

module ndn (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               interest_valid,
    output logic               interest_ready,
    input  ndn_pkg::interest_t interest,
    input  logic               data_valid,
    output logic               data_ready,
    input  ndn_pkg::data_t     data,
    input  logic               fib_wr_valid,
    input  ndn_pkg::fib_idx_t  fib_wr_idx,
    input  ndn_pkg::route_t    fib_wr_route,
    output logic               out_valid,
    input  logic               out_ready,
    output ndn_pkg::resp_t     resp
);
    import ndn_pkg::*;

    logic      tbl_req_valid;                          // pit to hash table
    tbl_op_e   tbl_req_op;
    name_t     tbl_req_name;
    name_len_t tbl_req_len;
    logic      tbl_rsp_occupied;                       // hash table to pit
    name_t     tbl_rsp_name;
    name_len_t tbl_rsp_len;
    slot_t     tbl_rsp_slot;
    slot_t     cs_addr;                                // pit to store
    logic      cs_we;
    name_t     cs_wr_name;
    name_len_t cs_wr_len;
    byte_t     cs_wr_byte;
    logic      cs_rd_valid;                            // store to pit
    name_t     cs_rd_name;
    name_len_t cs_rd_len;
    byte_t     cs_rd_byte;
    logic      fib_req_valid;                          // pit to fib
    name_t     fib_req_name;
    name_len_t fib_req_len;
    logic      fib_rsp_valid;                          // fib to pit
    logic      fib_rsp_hit;
    route_t    fib_rsp_route;

    pit u_pit (.*);                                    // names match one to one

    pit_hash_table u_pit_hash_table (
        .clk, .rst_n,
        .req_valid    (tbl_req_valid),    .req_op       (tbl_req_op),
        .req_name     (tbl_req_name),     .req_len      (tbl_req_len),
        .rsp_occupied (tbl_rsp_occupied), .rsp_name     (tbl_rsp_name),
        .rsp_len      (tbl_rsp_len),      .rsp_slot     (tbl_rsp_slot)
    );

    fib u_fib (
        .clk, .rst_n,
        .wr_valid  (fib_wr_valid),  .wr_idx   (fib_wr_idx),   .wr_route  (fib_wr_route),
        .req_valid (fib_req_valid), .req_name (fib_req_name), .req_len   (fib_req_len),
        .rsp_valid (fib_rsp_valid), .rsp_hit  (fib_rsp_hit),  .rsp_route (fib_rsp_route)
    );

    content_store u_content_store (
        .clk, .rst_n,
        .addr     (cs_addr),     .we      (cs_we),
        .wr_name  (cs_wr_name),  .wr_len  (cs_wr_len),  .wr_byte (cs_wr_byte),
        .rd_valid (cs_rd_valid), .rd_name (cs_rd_name),
        .rd_len   (cs_rd_len),   .rd_byte (cs_rd_byte)
    );

endmodule

// File: testbench/ndn_chk.sv
`timescale 1ns/100ps

module ndn_chk (
    input logic           clk,
    input logic           rst_n,
    input logic           interest_valid,
    input logic           interest_ready,
    input logic           data_valid,
    input logic           data_ready,
    input logic           out_valid,
    input logic           out_ready,
    input ndn_pkg::resp_t resp
);
    int unsigned fail_count = 0;                       // failed assertion count

    reset_quiet: assert property (@(posedge clk) !rst_n |=> !out_valid)
        else begin
            fail_count++;
            $error("out_valid high after a reset edge");
        end

    resp_held: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> $stable(resp))
        else begin
            fail_count++;
            $error("resp changed while stalled");
        end

    busy_not_ready: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> !interest_ready && !data_ready)
        else begin
            fail_count++;
            $error("input ready while a response is pending");
        end

    one_transfer: assert property (@(posedge clk) disable iff (!rst_n)
        !(interest_valid && interest_ready && data_valid && data_ready))
        else begin
            fail_count++;
            $error("interest and data accepted in one cycle");
        end

endmodule

bind ndn ndn_chk u_ndn_chk (.*);

// File: testbench/ndn_tb.sv
`timescale 1ns/100ps

module ndn_tb;
    import ndn_pkg::*;

    typedef enum logic [2:0] {OP_FIB, OP_INT, OP_DATA, OP_BOTH, OP_NEXT} op_e;

    typedef struct packed {
        op_e        op;
        name_t      name;
        name_len_t  len;
        byte_t      payload;
        fib_idx_t   idx;
        route_t     route;                             // fib write or expected route
        resp_kind_e exp_kind;
        byte_t      exp_payload;
    } row_t;

    logic        clk;
    logic        rst_n;
    logic        interest_valid;
    logic        interest_ready;
    interest_t   interest;
    logic        data_valid;
    logic        data_ready;
    data_t       data;
    logic        fib_wr_valid;
    fib_idx_t    fib_wr_idx;
    route_t      fib_wr_route;
    logic        out_valid;
    logic        out_ready;
    resp_t       resp;
    row_t        rows [$];                             // stimulus and expected values
    logic        rows_ready;
    int unsigned checks;
    int unsigned errors;

    ndn u_ndn (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // name with every bit below the top len bits cleared
    function automatic name_t top_bits(input name_t name, input name_len_t len);
        name_t masked;
        masked = '0;
        for (int b = 0; b < 64; b++) begin
            if (b >= 64 - int'(len)) begin
                masked[b] = name[b];
            end
        end
        return masked;
    endfunction

    // fold the sixteen nibbles of the kept prefix
    function automatic slot_t slot_of(input name_t name, input name_len_t len);
        name_t masked;
        slot_t h;
        masked = top_bits(name, len);
        h = '0;
        for (int i = 0; i < 16; i++) begin
            h = h ^ masked[4*i +: 4];
        end
        return h;
    endfunction

    // another name in the same slot by flipping top byte bits
    function automatic name_t colliding_name(input name_t name, input name_len_t len);
        name_t cand;
        cand = name;
        for (int k = 1; k < 256; k++) begin
            cand = name ^ (name_t'(k) << 56);
            if (slot_of(cand, len) == slot_of(name, len)) begin
                return cand;
            end
        end
        return cand;
    endfunction

    function automatic row_t make_row(input op_e op, input name_t name, input name_len_t len,
                                      input byte_t payload, input fib_idx_t idx,
                                      input route_t route, input resp_kind_e kind,
                                      input byte_t exp_payload);
        return '{op, name, len, payload, idx, route, kind, exp_payload};
    endfunction

    task automatic build_table();
        name_t  n1;
        name_t  n1_alt;
        name_t  n2;
        name_t  n3;
        name_t  n4;
        name_t  n5;
        route_t r8;
        route_t r16;
        route_t r24;
        route_t none;
        n1     = 64'hAABB_CCDD_0000_0000;              // slot 0
        n1_alt = 64'hAABB_CCDD_1357_9BDF;              // same name with junk below len
        n2     = 64'h1234_5678_0000_0000;              // slot 8 with no route
        n3     = 64'hAABB_1200_0000_0000;              // slot 3 at len 24
        n4     = 64'hAA90_0000_0000_0000;              // slot 9 at len 16
        n5     = 64'h0F00_0000_0000_0000;              // slot 15 at len 8
        r8     = '{prefix: 64'hAA00_0000_0000_0000, len: 6'd8};
        r16    = '{prefix: 64'hAABB_0000_0000_0000, len: 6'd16};
        r24    = '{prefix: 64'hAABB_CC00_0000_0000, len: 6'd24};
        none   = '0;
        rows.push_back(make_row(OP_FIB, '0, '0, 8'h00, 3'd0, r8, RESP_DROP, 8'h00));
        rows.push_back(make_row(OP_FIB, '0, '0, 8'h00, 3'd1, r16, RESP_DROP, 8'h00));
        rows.push_back(make_row(OP_FIB, '0, '0, 8'h00, 3'd2, r24, RESP_DROP, 8'h00));
        rows.push_back(make_row(OP_INT, n1, 6'd32, 8'h00, 3'd0, r24, RESP_FWD, 8'h00));
        rows.push_back(make_row(OP_INT, n3, 6'd24, 8'h00, 3'd0, r16, RESP_FWD, 8'h00));
        rows.push_back(make_row(OP_INT, n4, 6'd16, 8'h00, 3'd0, r8, RESP_FWD, 8'h00));
        rows.push_back(make_row(OP_INT, n2, 6'd32, 8'h00, 3'd0, none, RESP_NACK_NOROUTE, 8'h00));
        rows.push_back(make_row(OP_INT, n2, 6'd32, 8'h00, 3'd0, none, RESP_NACK_NOROUTE, 8'h00));
        rows.push_back(make_row(OP_INT, n1_alt, 6'd32, 8'h00, 3'd0, none, RESP_AGGR, 8'h00));
        rows.push_back(make_row(OP_INT, colliding_name(n1, 6'd32), 6'd32, 8'h00, 3'd0, none,
                                RESP_NACK_COLLIDE, 8'h00));
        rows.push_back(make_row(OP_DATA, n1, 6'd32, 8'h5A, 3'd0, none, RESP_DELIVER, 8'h5A));
        rows.push_back(make_row(OP_DATA, n1, 6'd32, 8'h5A, 3'd0, none, RESP_DROP, 8'h00));
        rows.push_back(make_row(OP_INT, n1_alt, 6'd32, 8'h00, 3'd0, none, RESP_CACHE, 8'h5A));
        rows.push_back(make_row(OP_DATA, n5, 6'd8, 8'hC3, 3'd0, none, RESP_DROP, 8'h00));
        rows.push_back(make_row(OP_INT, n5, 6'd8, 8'h00, 3'd0, none, RESP_NACK_NOROUTE, 8'h00));
        rows.push_back(make_row(OP_DATA, n3, 6'd24, 8'h3C, 3'd0, none, RESP_DELIVER, 8'h3C));
        rows.push_back(make_row(OP_BOTH, n4, 6'd16, 8'h77, 3'd0, none, RESP_DELIVER, 8'h77));
        rows.push_back(make_row(OP_NEXT, n4, 6'd16, 8'h00, 3'd0, none, RESP_CACHE, 8'h77));
    endtask

    // one clock with handshakes sampled at the falling edge
    task automatic step(output logic out_x, output resp_t seen);
        logic int_x;
        logic data_x;
        @(negedge clk);
        int_x  = interest_valid && interest_ready;
        data_x = data_valid && data_ready;
        out_x  = out_valid && out_ready;
        seen   = resp;
        @(posedge clk);
        #1;
        if (int_x) begin
            interest_valid = 1'b0;                     // accepted at this edge
        end
        if (data_x) begin
            data_valid = 1'b0;
        end
        out_ready = ($urandom % 4) != 0;               // stall about one cycle in four
    endtask

    task automatic wait_response(output resp_t rsp);
        logic out_x;
        out_x = 1'b0;
        while (!out_x) begin
            step(out_x, rsp);
        end
    endtask

    task automatic check_response(input int row, input row_t r, input resp_t rsp,
                                  output logic ok);
        name_t exp_name;
        ok       = 1'b1;
        exp_name = top_bits(r.name, r.len);            // bits below len are not the name
        checks += 5;
        assert (rsp.kind == r.exp_kind) else begin
            $display("Mismatch row %0d resp.kind: got %h expected %h", row, rsp.kind, r.exp_kind);
            ok = 1'b0;
            errors++;
        end
        assert (rsp.name == exp_name) else begin
            $display("Mismatch row %0d resp.name: got %h expected %h", row, rsp.name, exp_name);
            ok = 1'b0;
            errors++;
        end
        assert (rsp.len == r.len) else begin
            $display("Mismatch row %0d resp.len: got %h expected %h", row, rsp.len, r.len);
            ok = 1'b0;
            errors++;
        end
        assert (rsp.route == r.route) else begin
            $display("Mismatch row %0d resp.route: got %h expected %h", row, rsp.route, r.route);
            ok = 1'b0;
            errors++;
        end
        assert (rsp.payload == r.exp_payload) else begin
            $display("Mismatch row %0d resp.payload: got %h expected %h",
                     row, rsp.payload, r.exp_payload);
            ok = 1'b0;
            errors++;
        end
    endtask

    initial begin
        row_t  r;
        op_e   op;
        resp_t rsp;
        logic  ok;
        logic  out_x;
        void'($urandom(32'hb6e0));                     // fixed seed
        rows_ready     = 1'b0;
        checks         = 0;
        errors         = 0;
        rst_n          = 1'b0;
        interest_valid = 1'b0;
        interest       = '0;
        data_valid     = 1'b0;
        data           = '0;
        fib_wr_valid   = 1'b0;
        fib_wr_idx     = '0;
        fib_wr_route   = '0;
        out_ready      = 1'b1;
        build_table();
        rows_ready = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < rows.size(); i++) begin
            r  = rows[i];
            op = r.op;
            case (op)
                OP_FIB: begin
                    fib_wr_valid = 1'b1;
                    fib_wr_idx   = r.idx;
                    fib_wr_route = r.route;
                    step(out_x, rsp);
                    fib_wr_valid = 1'b0;
                end
                OP_INT: begin
                    interest       = '{name: r.name, len: r.len};
                    interest_valid = 1'b1;
                end
                OP_DATA: begin
                    data       = '{name: r.name, len: r.len, payload: r.payload};
                    data_valid = 1'b1;
                end
                OP_BOTH: begin                         // same cycle so data must win
                    interest       = '{name: r.name, len: r.len};
                    data           = '{name: r.name, len: r.len, payload: r.payload};
                    interest_valid = 1'b1;
                    data_valid     = 1'b1;
                end
                default: ;                             // response of a held interest
            endcase
            if (op == OP_FIB) begin
                $display("row %0d %s idx %0d: written", i, op.name(), r.idx);
            end else begin
                wait_response(rsp);
                check_response(i, r, rsp, ok);
                $display("row %0d %s kind %0h: %s", i, op.name(), rsp.kind, ok ? "ok" : "error");
            end
        end
        errors += u_ndn.u_ndn_chk.fail_count;          // bound assertion failures
        $display("rows %0d checks %0d errors %0d", rows.size(), checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        wait (rows_ready === 1'b1);
        repeat (rows.size() * 40) @(posedge clk);      // forty cycles per row
        $display("timeout: responses stopped arriving after %0d cycles", rows.size() * 40);
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: list.f
source/ndn_pkg.sv
source/pit_hash_table.sv
source/fib.sv
source/content_store.sv
source/pit.sv
source/ndn.sv
testbench/ndn_chk.sv
testbench/ndn_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f list.f --top-module ndn_tb -o ndn_sim --Mdir obj_dir
./obj_dir/ndn_sim +verilator+error+limit+100 | tee sim.log
if grep -q "^TB PASSED$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
